// File: all.f
+incdir+testbench
hdl/soc_pkg.sv
hdl/core_decode.sv
hdl/core_execute.sv
hdl/core_result.sv
hdl/core.sv
hdl/soc_ram.sv
hdl/soc_top.sv
testbench/tb_soc.sv

// File: Makefile
TOP := tb_soc

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: testbench/tb_soc_model.svh
`ifndef TB_SOC_MODEL_SVH
`define TB_SOC_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction-set model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
data_t model_regs [NUM_REGS];
data_t model_dmem [MEM_WORDS];
addr_t model_pc;

task automatic reset_model();
    for (int i = 0; i < NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
        model_dmem[i] = '0;
    end
    model_pc = '0;
endtask

task automatic run_model();
    instr_t w;
    data_t  a;
    data_t  b;
    data_t  imm;
    data_t  ea;
    data_t  value;
    logic   wr;
    logic   done;
    reset_model();
    done = 1'b0;
    while (!done) begin
        w     = prog[model_pc];
        a     = model_regs[w.rs];
        b     = model_regs[w.imm[2:0]];
        imm   = {{10{w.imm[5]}}, w.imm};
        ea    = a + imm;
        value = '0;
        wr    = 1'b1;
        case (w.opcode)
            OP_ADDI: value = a + imm;
            OP_ADD:  value = a + b;
            OP_SUB:  value = a - b;
            OP_XOR:  value = a ^ b;
            OP_LD:   value = model_dmem[ea[5:0]];
            OP_ST: begin
                model_dmem[ea[5:0]] = model_regs[w.rd];
                wr = 1'b0;
            end
            // halt and every undefined opcode stop here.
            default: done = 1'b1;
        endcase
        if (!done) begin
            if (wr && w.rd != '0) begin
                model_regs[w.rd] = value;
            end
            model_pc = model_pc + 6'd1;
        end
    end
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare tasks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("Fail at %0t: %s got %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("Fail at %0t: %s got %h, expected %h", $time, name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        stop_with_failure($sformatf("Fail at %0t: %s got %b, expected %b", $time, name, got, exp));
    end
endtask

`endif

// File: testbench/tb_soc.sv
`timescale 1ns/1ps

module tb_soc;
    import soc_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int NUM_PROGRAMS   = 8;

    logic     clk;
    logic     rst_n;
    logic     load_en;
    logic     load_ready;
    addr_t    load_addr;
    instr_t   load_data;
    logic     start;
    logic     halted;
    addr_t    reg_pc;
    reg_idx_t reg_read_sel;
    data_t    reg_read_data;
    integer   seed;
    instr_t   prog [MEM_WORDS];
    int       prog_len;

    soc_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_en       (load_en),
        .load_ready    (load_ready),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .start         (start),
        .halted        (halted),
        .reg_pc        (reg_pc),
        .reg_read_sel  (reg_read_sel),
        .reg_read_data (reg_read_data)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error.");
    endtask

    `include "tb_soc_model.svh"

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program generation.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic make_program();
        int          count;
        int          r;
        logic [31:0] bits;
        count = 10 + rand_below(31);
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog[i] = '0;
        end
        for (int i = 0; i <= count; i++) begin
            bits    = $random(seed);
            prog[i] = bits[15:0];
            r       = rand_below(40);
            if (i == count) prog[i].opcode = OP_HALT;
            else if (r < 8) prog[i].opcode = OP_ADDI;
            else if (r < 14) prog[i].opcode = OP_ADD;
            else if (r < 19) prog[i].opcode = OP_SUB;
            else if (r < 24) prog[i].opcode = OP_XOR;
            else if (r < 31) prog[i].opcode = OP_LD;
            else if (r < 39) prog[i].opcode = OP_ST;
            else prog[i].opcode = 4'(7 + rand_below(9));
            // half the accesses hit a few low addresses so loads meet earlier stores.
            if (r >= 24 && r < 39 && rand_below(2) == 0) begin
                prog[i].rs  = '0;
                prog[i].imm = 6'(rand_below(8));
            end
        end
        prog_len = count + 1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // run control.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apply_reset();
        @(negedge clk);
        rst_n   = 1'b0;
        load_en = 1'b0;
        start   = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        reset_model();
    endtask

    task automatic load_program();
        int waited;
        @(negedge clk);
        for (int i = 0; i < prog_len; i++) begin
            load_en   = 1'b1;
            load_addr = addr_t'(i);
            load_data = prog[i];
            waited    = 0;
            // ready seen at a falling edge means the next rising edge accepts.
            while (!load_ready) begin
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    stop_with_failure("timed out waiting for load_ready");
                end
            end
            @(negedge clk);
        end
        load_en = 1'b0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_halt();
        int waited;
        waited = 0;
        while (!halted) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_with_failure("timed out waiting for halted");
            end
        end
    endtask

    task automatic check_state(input logic exp_halted);
        check_flag("halted", halted, exp_halted);
        // the core is idle here, so no load can be taken.
        check_flag("load_ready", load_ready, 1'b0);
        check_addr("reg_pc", reg_pc, model_pc);
        for (int i = 0; i < NUM_REGS; i++) begin
            @(negedge clk);
            reg_read_sel = reg_idx_t'(i);
            #1;
            check_data($sformatf("reg_read_data[r%0d]", i), reg_read_data, model_regs[i]);
        end
    endtask

    initial begin
        seed         = 38;
        clk          = 1'b0;
        rst_n        = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        start        = 1'b0;
        reg_read_sel = '0;
        for (int p = 0; p < NUM_PROGRAMS; p++) begin
            apply_reset();
            check_state(1'b0);
            make_program();
            run_model();
            load_program();
            wait_for_halt();
            check_state(1'b1);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: hdl/soc_top.sv
`timescale 1ns/1ps

module soc_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_en,
    output logic              load_ready,
    input  soc_pkg::addr_t    load_addr,
    input  soc_pkg::instr_t   load_data,
    input  logic              start,
    output logic              halted,
    output soc_pkg::addr_t    reg_pc,
    input  soc_pkg::reg_idx_t reg_read_sel,
    output soc_pkg::data_t    reg_read_data
);
    import soc_pkg::*;

    logic   imem_req_valid;
    logic   imem_req_ready;
    logic   imem_req_write;
    addr_t  imem_req_addr;
    instr_t imem_req_wdata;
    logic   imem_resp_valid;
    instr_t imem_resp_rdata;
    logic   dmem_req_valid;
    logic   dmem_req_ready;
    logic   dmem_req_write;
    addr_t  dmem_req_addr;
    data_t  dmem_req_wdata;
    logic   dmem_resp_valid;
    data_t  dmem_resp_rdata;

    core core0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_en         (load_en),
        .load_ready      (load_ready),
        .load_addr       (load_addr),
        .load_data       (load_data),
        .start           (start),
        .halted          (halted),
        .reg_pc          (reg_pc),
        .reg_read_sel    (reg_read_sel),
        .reg_read_data   (reg_read_data),
        .imem_req_valid  (imem_req_valid),
        .imem_req_ready  (imem_req_ready),
        .imem_req_write  (imem_req_write),
        .imem_req_addr   (imem_req_addr),
        .imem_req_wdata  (imem_req_wdata),
        .imem_resp_valid (imem_resp_valid),
        .imem_resp_rdata (imem_resp_rdata),
        .dmem_req_valid  (dmem_req_valid),
        .dmem_req_ready  (dmem_req_ready),
        .dmem_req_write  (dmem_req_write),
        .dmem_req_addr   (dmem_req_addr),
        .dmem_req_wdata  (dmem_req_wdata),
        .dmem_resp_valid (dmem_resp_valid),
        .dmem_resp_rdata (dmem_resp_rdata)
    );

    // instruction memory.
    soc_ram #(
        .payload_t (instr_t),
        .LATENCY   (IMEM_LATENCY)
    ) imem0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (imem_req_valid),
        .req_ready  (imem_req_ready),
        .req_write  (imem_req_write),
        .req_addr   (imem_req_addr),
        .req_wdata  (imem_req_wdata),
        .resp_valid (imem_resp_valid),
        .resp_rdata (imem_resp_rdata)
    );

    // data memory.
    soc_ram #(
        .payload_t (data_t),
        .LATENCY   (DMEM_LATENCY)
    ) dmem0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (dmem_req_valid),
        .req_ready  (dmem_req_ready),
        .req_write  (dmem_req_write),
        .req_addr   (dmem_req_addr),
        .req_wdata  (dmem_req_wdata),
        .resp_valid (dmem_resp_valid),
        .resp_rdata (dmem_resp_rdata)
    );

endmodule

// File: hdl/soc_ram.sv
`timescale 1ns/1ps

module soc_ram #(
    parameter type payload_t = soc_pkg::data_t,
    parameter int  LATENCY   = 1
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           req_valid,
    output logic           req_ready,
    input  logic           req_write,
    input  soc_pkg::addr_t req_addr,
    input  payload_t       req_wdata,
    output logic           resp_valid,
    output payload_t       resp_rdata
);
    import soc_pkg::*;

    payload_t             mem [MEM_WORDS];
    payload_t             rdata_q;
    logic [LAT_CNT_W-1:0] busy_cnt;
    logic                 accept;

    assign req_ready = (busy_cnt == '0);
    assign accept    = req_valid && req_ready;

    // contents clear on reset so every run starts from zeroed memory.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && req_write) begin
            mem[req_addr] <= req_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !req_write) begin
            rdata_q <= mem[req_addr];
        end
    end

    // counts down to the response cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (accept && !req_write) begin
            busy_cnt <= LAT_CNT_W'(LATENCY);
        end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    assign resp_valid = (busy_cnt == LAT_CNT_W'(1));
    assign resp_rdata = rdata_q;

    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && !req_ready) |=> (req_valid && $stable(req_addr) && $stable(req_write)));

endmodule

// File: hdl/core.sv
`timescale 1ns/1ps

module core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_en,
    output logic              load_ready,
    input  soc_pkg::addr_t    load_addr,
    input  soc_pkg::instr_t   load_data,
    input  logic              start,
    output logic              halted,
    output soc_pkg::addr_t    reg_pc,
    input  soc_pkg::reg_idx_t reg_read_sel,
    output soc_pkg::data_t    reg_read_data,
    output logic              imem_req_valid,
    input  logic              imem_req_ready,
    output logic              imem_req_write,
    output soc_pkg::addr_t    imem_req_addr,
    output soc_pkg::instr_t   imem_req_wdata,
    input  logic              imem_resp_valid,
    input  soc_pkg::instr_t   imem_resp_rdata,
    output logic              dmem_req_valid,
    input  logic              dmem_req_ready,
    output logic              dmem_req_write,
    output soc_pkg::addr_t    dmem_req_addr,
    output soc_pkg::data_t    dmem_req_wdata,
    input  logic              dmem_resp_valid,
    input  soc_pkg::data_t    dmem_resp_rdata
);
    import soc_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_MEM,
        ST_MEM_WAIT
    } state_t;

    state_t   state;
    instr_t   instr_q;
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    data_t    imm;
    logic     writes_reg;
    logic     is_load;
    logic     is_store;
    logic     is_halt;
    logic     mem_op;
    data_t    rs_value;
    data_t    rt_value;
    data_t    rd_value;
    data_t    alu_result;
    addr_t    mem_addr;
    logic     wb_en;
    reg_idx_t wb_rd;
    data_t    wb_data;

    assign mem_op = is_load || is_store;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load_en) begin
                        state <= ST_LOAD;
                    end else if (start && !halted) begin
                        state <= ST_FETCH;
                    end
                end
                ST_LOAD: begin
                    if (!load_en) begin
                        state <= ST_IDLE;
                    end
                end
                ST_FETCH: begin
                    if (imem_req_ready) begin
                        state <= ST_FETCH_WAIT;
                    end
                end
                ST_FETCH_WAIT: begin
                    if (imem_resp_valid) begin
                        state <= ST_MEM;
                    end
                end
                // writeback for plain ops, data request for ld/st.
                ST_MEM: begin
                    if (is_halt) begin
                        state <= ST_IDLE;
                    end else if (!mem_op) begin
                        state <= ST_FETCH;
                    end else if (dmem_req_ready) begin
                        state <= is_load ? ST_MEM_WAIT : ST_FETCH;
                    end
                end
                ST_MEM_WAIT: begin
                    if (dmem_resp_valid) begin
                        state <= ST_FETCH;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FETCH_WAIT && imem_resp_valid) begin
            instr_q <= imem_resp_rdata;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // datapath.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    core_decode decode0 (
        .instr      (instr_q),
        .opcode     (opcode),
        .rd         (rd),
        .rs         (rs),
        .rt         (rt),
        .imm        (imm),
        .writes_reg (writes_reg),
        .is_load    (is_load),
        .is_store   (is_store),
        .is_halt    (is_halt)
    );

    core_execute execute0 (
        .opcode     (opcode),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .imm        (imm),
        .alu_result (alu_result),
        .mem_addr   (mem_addr)
    );

    // store completes at the data accept.
    assign wb_en = (state == ST_MEM && (!mem_op || (is_store && dmem_req_ready)))
                || (state == ST_MEM_WAIT && dmem_resp_valid);
    // no-write ops target r0, which discards the data.
    assign wb_rd   = writes_reg ? rd : '0;
    assign wb_data = (state == ST_MEM_WAIT) ? dmem_resp_rdata : alu_result;

    core_result result0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .wb_halt  (is_halt),
        .rs       (rs),
        .rt       (rt),
        .rd       (rd),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .rd_value (rd_value),
        .pc       (reg_pc),
        .halted   (halted),
        .dbg_sel  (reg_read_sel),
        .dbg_data (reg_read_data)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory ports.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign imem_req_valid = (state == ST_LOAD && load_en) || (state == ST_FETCH);
    assign imem_req_write = (state == ST_LOAD);
    assign imem_req_addr  = (state == ST_LOAD) ? load_addr : reg_pc;
    assign imem_req_wdata = load_data;
    assign load_ready     = (state == ST_LOAD) && imem_req_ready;

    assign dmem_req_valid = (state == ST_MEM) && mem_op;
    assign dmem_req_write = is_store;
    assign dmem_req_addr  = mem_addr;
    assign dmem_req_wdata = rd_value;

    // the fetch read has fully retired before any data request.
    a_one_port: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_valid |-> (!imem_req_valid && imem_req_ready));

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !halted) |-> (state == ST_IDLE));

endmodule

// File: hdl/core_result.sv
`timescale 1ns/1ps

module core_result (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wb_en,
    input  soc_pkg::reg_idx_t wb_rd,
    input  soc_pkg::data_t    wb_data,
    input  logic              wb_halt,
    input  soc_pkg::reg_idx_t rs,
    input  soc_pkg::reg_idx_t rt,
    input  soc_pkg::reg_idx_t rd,
    output soc_pkg::data_t    rs_value,
    output soc_pkg::data_t    rt_value,
    output soc_pkg::data_t    rd_value,
    output soc_pkg::addr_t    pc,
    output logic              halted,
    input  soc_pkg::reg_idx_t dbg_sel,
    output soc_pkg::data_t    dbg_data
);
    import soc_pkg::*;

    // entry 0 is never written, so it reads zero.
    data_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // pc holds on the halt itself.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (wb_en) begin
            if (wb_halt) begin
                halted <= 1'b1;
            end else begin
                pc <= pc + addr_t'(1);
            end
        end
    end

    // read ports.
    assign rs_value = regs[rs];
    assign rt_value = regs[rt];
    assign rd_value = regs[rd];
    assign dbg_data = regs[dbg_sel];

endmodule

// File: hdl/core_execute.sv
`timescale 1ns/1ps

module core_execute (
    input  soc_pkg::opcode_t opcode,
    input  soc_pkg::data_t   rs_value,
    input  soc_pkg::data_t   rt_value,
    input  soc_pkg::data_t   imm,
    output soc_pkg::data_t   alu_result,
    output soc_pkg::addr_t   mem_addr
);
    import soc_pkg::*;

    data_t operand_b;
    data_t add_b;
    data_t sum;
    data_t eff_addr;
    logic  subtract;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // adder/subtractor.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign subtract  = (opcode == OP_SUB);
    assign operand_b = (opcode == OP_ADDI) ? imm : rt_value;

    // two's complement subtract through the same adder.
    assign add_b = subtract ? ~operand_b : operand_b;
    assign sum   = rs_value + add_b + data_t'(subtract);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // effective address.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign eff_addr = rs_value + imm;
    // word address wraps inside the memory.
    assign mem_addr = eff_addr[$bits(addr_t)-1:0];

    // result select.
    always_comb begin
        case (opcode)
            OP_XOR: begin
                alu_result = rs_value ^ rt_value;
            end
            OP_LD, OP_ST: begin
                alu_result = eff_addr;
            end
            default: begin
                alu_result = sum;
            end
        endcase
    end

endmodule

// File: hdl/core_decode.sv
`timescale 1ns/1ps

module core_decode (
    input  soc_pkg::instr_t   instr,
    output soc_pkg::opcode_t  opcode,
    output soc_pkg::reg_idx_t rd,
    output soc_pkg::reg_idx_t rs,
    output soc_pkg::reg_idx_t rt,
    output soc_pkg::data_t    imm,
    output logic              writes_reg,
    output logic              is_load,
    output logic              is_store,
    output logic              is_halt
);
    import soc_pkg::*;

    // register fields.
    assign rd = instr.rd;
    assign rs = instr.rs;
    assign rt = instr.imm[$bits(reg_idx_t)-1:0];

    // sign extend the short immediate.
    assign imm = {{($bits(data_t) - IMM_W){instr.imm[IMM_W-1]}}, instr.imm};

    // anything undefined collapses to a halt.
    always_comb begin
        case (instr.opcode)
            OP_ADDI,
            OP_ADD,
            OP_SUB,
            OP_XOR,
            OP_LD,
            OP_ST: begin
                opcode = opcode_t'(instr.opcode);
            end
            default: begin
                opcode = OP_HALT;
            end
        endcase
    end

    always_comb begin
        writes_reg = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_halt    = 1'b0;
        case (opcode)
            OP_ADDI, OP_ADD, OP_SUB, OP_XOR: writes_reg = 1'b1;
            OP_LD: begin
                writes_reg = 1'b1;
                is_load    = 1'b1;
            end
            OP_ST: is_store = 1'b1;
            default: is_halt = 1'b1;
        endcase
    end

endmodule

// File: hdl/soc_pkg.sv
package soc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sizes and timing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int MEM_WORDS    = 64;
    localparam int IMEM_LATENCY = 1;
    localparam int DMEM_LATENCY = 3;
    // wide enough for any latency up to 15.
    localparam int LAT_CNT_W    = 4;
    localparam int NUM_REGS     = 8;
    localparam int IMM_W        = 6;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data and instruction types.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [15:0] data_t;
    typedef logic [$clog2(MEM_WORDS)-1:0] addr_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_ADDI = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_XOR  = 4'h3,
        OP_LD   = 4'h4,
        OP_ST   = 4'h5,
        OP_HALT = 4'h6
    } opcode_t;

    // opcode is kept raw so undefined encodings can be stored and decoded.
    // low 3 bits of imm carry rt for register forms.
    typedef struct packed {
        logic [3:0]       opcode;
        reg_idx_t         rd;
        reg_idx_t         rs;
        logic [IMM_W-1:0] imm;
    } instr_t;

endpackage
